// ==== design/pctl_cfg.svh ====
// Pipeline control configuration
// Widths, opcode and function codes of the supported instructions

`ifndef PCTL_CFG_SVH
`define PCTL_CFG_SVH

// Widths fixed by the instruction set
`define PCTL_INST_W      32
`define PCTL_REG_ADDR_W  5

// Opcode field in bits 31 to 26
`define PCTL_OP_SPECIAL  6'h00
`define PCTL_OP_ADDIU    6'h09
`define PCTL_OP_LUI      6'h0f
`define PCTL_OP_BEQ      6'h04
`define PCTL_OP_BNE      6'h05
`define PCTL_OP_LW       6'h23
`define PCTL_OP_SW       6'h2b

// Function field of SPECIAL words
`define PCTL_FN_ADDU     6'h21
`define PCTL_FN_SUBU     6'h23
`define PCTL_FN_AND      6'h24
`define PCTL_FN_OR       6'h25

`define PCTL_REG_ZERO    5'd0   // Hardwired zero register

`endif

// ==== design/pctl_pkg.sv ====
// Pipeline control types
// Decode enums and the packed structs passed between the stages

`include "pctl_cfg.svh"

package pctl_pkg;

  typedef logic [`PCTL_INST_W-1:0]     inst_word_t;
  typedef logic [`PCTL_REG_ADDR_W-1:0] reg_addr_t;

  // ------------------------------------------------------------------
  // Decoded field encodings
  // ------------------------------------------------------------------

  typedef enum logic [2:0] {
    ALU_ADD  = 3'd0,
    ALU_SUB  = 3'd1,
    ALU_AND  = 3'd2,
    ALU_OR   = 3'd3,
    ALU_LUI  = 3'd4,
    ALU_NONE = 3'd7
  } alu_fn_e;

  typedef enum logic [1:0] {
    OP1_RDAT     = 2'd0,  // Register file
    OP1_SEXT_IMM = 2'd1,
    OP1_ZEXT_IMM = 2'd2,
    OP1_NONE     = 2'd3
  } op1_sel_e;

  typedef enum logic {
    WB_ALU = 1'b0,
    WB_MEM = 1'b1   // Load data
  } wb_sel_e;

  typedef enum logic [1:0] {
    MEM_NONE  = 2'd0,
    MEM_LOAD  = 2'd1,
    MEM_STORE = 2'd2
  } mem_type_e;

  typedef enum logic [1:0] {
    BR_NONE = 2'd0,
    BR_EQ   = 2'd1,
    BR_NE   = 2'd2
  } br_type_e;

  // ------------------------------------------------------------------
  // Stage records
  // ------------------------------------------------------------------

  // Condition flags the datapath would compute
  typedef struct packed {
    logic eq;
    logic neg;
    logic zero;
  } br_flags_t;

  typedef struct packed {
    logic      legal;
    alu_fn_e   alu_fn;
    op1_sel_e  op1_sel;
    wb_sel_e   wb_sel;
    mem_type_e mem_type;
    logic      wen;
    reg_addr_t waddr;
  } ctrl_word_t;

  typedef struct packed {
    inst_word_t inst;
    ctrl_word_t ctrl;
    br_type_e   br_type;
    br_flags_t  flags;
  } dx_pkt_t;

  // Returned to the stage behind
  typedef struct packed {
    logic stall;
    logic squash;
  } back_t;

  // Pending register write, seen by the hazard check
  typedef struct packed {
    logic      val;
    logic      wen;
    reg_addr_t waddr;
  } wr_tag_t;

  typedef struct packed {
    inst_word_t inst;
    ctrl_word_t ctrl;
  } retire_t;

endpackage

// ==== design/pctl_stage_ctrl.sv ====
// Per-stage pipeline control
// Holds the stage valid bit and combines stall and squash going back

`timescale 1ns/1ps

module pctl_stage_ctrl (
  input  logic            clk,
  input  logic            reset,
  input  logic            prev_val,   // Valid offered by the stage behind
  input  logic            stall,      // This stage's own stall
  input  logic            squash,     // This stage kills younger work
  input  pctl_pkg::back_t next_back,
  output logic            reg_en,
  output logic            val,
  output pctl_pkg::back_t back
);

  logic hold;

  // Stage keeps its contents
  assign hold = (val && stall) || next_back.stall;

  // A squash from ahead empties the stage even while held
  assign reg_en = !hold || next_back.squash;

  assign back.stall  = hold;
  assign back.squash = (val && squash) || next_back.squash;

  always_ff @(posedge clk) begin
    if (reset) begin
      val <= 1'b0;
    end else if (reg_en) begin
      val <= prev_val && !next_back.squash;
    end
  end

endmodule

// ==== design/pctl_decode.sv ====
// Decode stage
// Accepts instructions, runs the decode table and stalls on
// read-after-write hazards against X, M and W

`timescale 1ns/1ps
`include "pctl_cfg.svh"

module pctl_decode (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 inst_val,
  output logic                 inst_rdy,
  input  pctl_pkg::inst_word_t inst,
  input  pctl_pkg::br_flags_t  flags,
  input  pctl_pkg::back_t      x_back,
  input  pctl_pkg::wr_tag_t    x_tag,
  input  pctl_pkg::wr_tag_t    m_tag,
  input  pctl_pkg::wr_tag_t    w_tag,
  output logic                 dx_val,
  output pctl_pkg::dx_pkt_t    dx
);

  logic                 run;        // Set on the first cycle out of reset
  logic                 d_reg_en;
  logic                 d_val;
  pctl_pkg::back_t      d_back;
  pctl_pkg::inst_word_t d_inst;
  pctl_pkg::br_flags_t  d_flags;

  logic [5:0]           opcode;
  logic [5:0]           funct;
  pctl_pkg::reg_addr_t  rs;
  pctl_pkg::reg_addr_t  rt;
  pctl_pkg::reg_addr_t  rd;

  pctl_pkg::ctrl_word_t dec;
  pctl_pkg::br_type_e   dec_br;
  pctl_pkg::alu_fn_e    r_fn;
  logic                 rs_en;
  logic                 rt_en;
  logic                 hazard;

  // ------------------------------------------------------------------
  // Stream acceptance and stage register
  // ------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      run <= 1'b0;
    end else begin
      run <= 1'b1;
    end
  end

  assign inst_rdy = run && !d_back.stall;

  pctl_stage_ctrl d_stage (
    .clk       (clk),
    .reset     (reset),
    .prev_val  (inst_val && inst_rdy),
    .stall     (hazard),
    .squash    (1'b0),
    .next_back (x_back),
    .reg_en    (d_reg_en),
    .val       (d_val),
    .back      (d_back)
  );

  always_ff @(posedge clk) begin
    if (d_reg_en) begin
      d_inst  <= inst;
      d_flags <= flags;
    end
  end

  // ------------------------------------------------------------------
  // Decode table
  // ------------------------------------------------------------------

  assign opcode = d_inst[31:26];
  assign funct  = d_inst[5:0];
  assign rs     = d_inst[25:21];
  assign rt     = d_inst[20:16];
  assign rd     = d_inst[15:11];

  function automatic pctl_pkg::ctrl_word_t cw(
    input logic                lg,
    input pctl_pkg::alu_fn_e   fn,
    input pctl_pkg::op1_sel_e  op1,
    input pctl_pkg::wb_sel_e   wb,
    input pctl_pkg::mem_type_e mt,
    input logic                we,
    input pctl_pkg::reg_addr_t wa
  );
    cw = '{legal: lg, alu_fn: fn, op1_sel: op1, wb_sel: wb,
           mem_type: mt, wen: we, waddr: wa};
  endfunction

  always_comb begin
    // Unknown words fall through as illegal with no side effects
    dec    = cw(1'b0, pctl_pkg::ALU_NONE, pctl_pkg::OP1_NONE, pctl_pkg::WB_ALU,
                pctl_pkg::MEM_NONE, 1'b0, `PCTL_REG_ZERO);
    dec_br = pctl_pkg::BR_NONE;
    r_fn   = pctl_pkg::ALU_NONE;
    rs_en  = 1'b0;
    rt_en  = 1'b0;
    if (d_inst == '0) begin
      dec.legal = 1'b1;                                     // nop
    end else begin
      case (opcode)
        `PCTL_OP_SPECIAL: begin
          case (funct)
            `PCTL_FN_ADDU: r_fn = pctl_pkg::ALU_ADD;
            `PCTL_FN_SUBU: r_fn = pctl_pkg::ALU_SUB;
            `PCTL_FN_AND:  r_fn = pctl_pkg::ALU_AND;
            `PCTL_FN_OR:   r_fn = pctl_pkg::ALU_OR;
            default:       r_fn = pctl_pkg::ALU_NONE;
          endcase
          if (r_fn != pctl_pkg::ALU_NONE) begin
            dec   = cw(1'b1, r_fn, pctl_pkg::OP1_RDAT, pctl_pkg::WB_ALU,
                       pctl_pkg::MEM_NONE, 1'b1, rd);
            rs_en = 1'b1;
            rt_en = 1'b1;
          end
        end
        `PCTL_OP_ADDIU: begin
          dec   = cw(1'b1, pctl_pkg::ALU_ADD, pctl_pkg::OP1_SEXT_IMM, pctl_pkg::WB_ALU,
                     pctl_pkg::MEM_NONE, 1'b1, rt);
          rs_en = 1'b1;
        end
        `PCTL_OP_LUI: begin
          dec = cw(1'b1, pctl_pkg::ALU_LUI, pctl_pkg::OP1_ZEXT_IMM, pctl_pkg::WB_ALU,
                   pctl_pkg::MEM_NONE, 1'b1, rt);
        end
        `PCTL_OP_BEQ, `PCTL_OP_BNE: begin
          dec    = cw(1'b1, pctl_pkg::ALU_NONE, pctl_pkg::OP1_RDAT, pctl_pkg::WB_ALU,
                      pctl_pkg::MEM_NONE, 1'b0, `PCTL_REG_ZERO);
          dec_br = (opcode == `PCTL_OP_BEQ) ? pctl_pkg::BR_EQ : pctl_pkg::BR_NE;
          rs_en  = 1'b1;
          rt_en  = 1'b1;
        end
        `PCTL_OP_LW: begin
          dec   = cw(1'b1, pctl_pkg::ALU_ADD, pctl_pkg::OP1_SEXT_IMM, pctl_pkg::WB_MEM,
                     pctl_pkg::MEM_LOAD, 1'b1, rt);
          rs_en = 1'b1;
        end
        `PCTL_OP_SW: begin
          dec   = cw(1'b1, pctl_pkg::ALU_ADD, pctl_pkg::OP1_SEXT_IMM, pctl_pkg::WB_ALU,
                     pctl_pkg::MEM_STORE, 1'b0, `PCTL_REG_ZERO);
          rs_en = 1'b1;
          rt_en = 1'b1;   // Store data register
        end
        default: ;
      endcase
    end
  end

  // ------------------------------------------------------------------
  // Hazard check, no bypassing so any pending writer blocks
  // ------------------------------------------------------------------

  function automatic logic hits(
    input pctl_pkg::wr_tag_t   tag,
    input pctl_pkg::reg_addr_t src
  );
    hits = tag.val && tag.wen && (tag.waddr != `PCTL_REG_ZERO) && (tag.waddr == src);
  endfunction

  assign hazard = d_val &&
    ((rs_en && (hits(x_tag, rs) || hits(m_tag, rs) || hits(w_tag, rs))) ||
     (rt_en && (hits(x_tag, rt) || hits(m_tag, rt) || hits(w_tag, rt))));

  // Bubble into X while stalled or squashed
  assign dx_val = d_val && !d_back.stall && !x_back.squash;
  assign dx     = '{inst: d_inst, ctrl: dec, br_type: dec_br, flags: d_flags};

endmodule

// ==== design/pctl_execute.sv ====
// Execute stage
// Resolves branches, raises the redirect and issues data-memory requests

`timescale 1ns/1ps

module pctl_execute (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 dx_val,
  input  pctl_pkg::dx_pkt_t    dx,
  output pctl_pkg::back_t      x_back,
  input  pctl_pkg::back_t      m_back,
  output pctl_pkg::wr_tag_t    x_tag,
  output logic                 dmemreq_val,
  input  logic                 dmemreq_rdy,
  output pctl_pkg::mem_type_e  dmemreq_type,
  output logic                 redirect,
  output logic                 xm_val,
  output pctl_pkg::ctrl_word_t xm_ctrl,
  output pctl_pkg::inst_word_t xm_inst
);

  logic              x_reg_en;
  logic              x_val;
  pctl_pkg::dx_pkt_t x_pkt;
  logic              x_mem;     // Load or store in X
  logic              taken;

  pctl_stage_ctrl x_stage (
    .clk       (clk),
    .reset     (reset),
    .prev_val  (dx_val),
    .stall     (x_mem && !dmemreq_rdy),
    .squash    (taken),
    .next_back (m_back),
    .reg_en    (x_reg_en),
    .val       (x_val),
    .back      (x_back)
  );

  always_ff @(posedge clk) begin
    if (x_reg_en) begin
      x_pkt <= dx;
    end
  end

  // ------------------------------------------------------------------
  // Branch resolution
  // ------------------------------------------------------------------

  always_comb begin
    case (x_pkt.br_type)
      pctl_pkg::BR_EQ: taken = x_pkt.flags.eq;
      pctl_pkg::BR_NE: taken = !x_pkt.flags.eq;
      default:         taken = 1'b0;
    endcase
  end

  assign redirect = x_val && taken;

  // ------------------------------------------------------------------
  // Data-memory request
  // ------------------------------------------------------------------

  assign x_mem        = x_pkt.ctrl.mem_type != pctl_pkg::MEM_NONE;
  assign dmemreq_val  = x_val && x_mem && !m_back.stall;  // M must be free for the response
  assign dmemreq_type = x_pkt.ctrl.mem_type;

  assign x_tag = '{val: x_val, wen: x_pkt.ctrl.wen, waddr: x_pkt.ctrl.waddr};

  // Forward to M
  assign xm_val  = x_val && !x_back.stall && !m_back.squash;
  assign xm_ctrl = x_pkt.ctrl;
  assign xm_inst = x_pkt.inst;

endmodule

// ==== design/pctl_result.sv ====
// Memory and writeback stages
// M waits for the data-memory response, W drives the retire port

`timescale 1ns/1ps

module pctl_result (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 xm_val,
  input  pctl_pkg::ctrl_word_t xm_ctrl,
  input  pctl_pkg::inst_word_t xm_inst,
  output pctl_pkg::back_t      m_back,
  output pctl_pkg::wr_tag_t    m_tag,
  output pctl_pkg::wr_tag_t    w_tag,
  input  logic                 dmemresp_val,
  output logic                 dmemresp_rdy,
  output logic                 ret_val,
  input  logic                 ret_rdy,
  output pctl_pkg::retire_t    ret
);

  logic                 m_reg_en;
  logic                 m_val;
  logic                 m_mem;
  logic                 mw_val;
  pctl_pkg::ctrl_word_t m_ctrl;
  pctl_pkg::inst_word_t m_inst;

  logic                 w_reg_en;
  logic                 w_val;
  pctl_pkg::back_t      w_back;
  pctl_pkg::ctrl_word_t w_ctrl;
  pctl_pkg::inst_word_t w_inst;

  // ------------------------------------------------------------------
  // M stage
  // ------------------------------------------------------------------

  pctl_stage_ctrl m_stage (
    .clk       (clk),
    .reset     (reset),
    .prev_val  (xm_val),
    .stall     (m_mem && !dmemresp_val),
    .squash    (1'b0),
    .next_back (w_back),
    .reg_en    (m_reg_en),
    .val       (m_val),
    .back      (m_back)
  );

  always_ff @(posedge clk) begin
    if (m_reg_en) begin
      m_ctrl <= xm_ctrl;
      m_inst <= xm_inst;
    end
  end

  assign m_mem        = m_ctrl.mem_type != pctl_pkg::MEM_NONE;
  assign dmemresp_rdy = m_val && m_mem && !w_back.stall;
  assign m_tag        = '{val: m_val, wen: m_ctrl.wen, waddr: m_ctrl.waddr};
  assign mw_val       = m_val && !m_back.stall && !w_back.squash;

  // ------------------------------------------------------------------
  // W stage, held by retire back-pressure
  // ------------------------------------------------------------------

  pctl_stage_ctrl w_stage (
    .clk       (clk),
    .reset     (reset),
    .prev_val  (mw_val),
    .stall     (!ret_rdy),
    .squash    (1'b0),
    .next_back ('0),        // Nothing ahead of W
    .reg_en    (w_reg_en),
    .val       (w_val),
    .back      (w_back)
  );

  always_ff @(posedge clk) begin
    if (w_reg_en) begin
      w_ctrl <= m_ctrl;
      w_inst <= m_inst;
    end
  end

  assign w_tag   = '{val: w_val, wen: w_ctrl.wen, waddr: w_ctrl.waddr};
  assign ret_val = w_val;
  assign ret     = '{inst: w_inst, ctrl: w_ctrl};

endmodule

// ==== design/pctl_top.sv ====
// Pipeline control unit
// Decode, execute and result stages joined into one block

`timescale 1ns/1ps

module pctl_top (
  input  logic                clk,
  input  logic                reset,

  // Instruction stream
  input  logic                inst_val,
  output logic                inst_rdy,
  input  pctl_pkg::inst_word_t inst,
  input  pctl_pkg::br_flags_t flags,

  // Data memory
  output logic                dmemreq_val,
  input  logic                dmemreq_rdy,
  output pctl_pkg::mem_type_e dmemreq_type,
  input  logic                dmemresp_val,
  output logic                dmemresp_rdy,

  // Retire port
  output logic                ret_val,
  input  logic                ret_rdy,
  output pctl_pkg::retire_t   ret,

  output logic                redirect
);

  logic                 dx_val;
  pctl_pkg::dx_pkt_t    dx;
  pctl_pkg::back_t      x_back;
  pctl_pkg::back_t      m_back;
  pctl_pkg::wr_tag_t    x_tag;
  pctl_pkg::wr_tag_t    m_tag;
  pctl_pkg::wr_tag_t    w_tag;
  logic                 xm_val;
  pctl_pkg::ctrl_word_t xm_ctrl;
  pctl_pkg::inst_word_t xm_inst;

  pctl_decode decode0 (
    .clk      (clk),
    .reset    (reset),
    .inst_val (inst_val),
    .inst_rdy (inst_rdy),
    .inst     (inst),
    .flags    (flags),
    .x_back   (x_back),
    .x_tag    (x_tag),
    .m_tag    (m_tag),
    .w_tag    (w_tag),
    .dx_val   (dx_val),
    .dx       (dx)
  );

  pctl_execute execute0 (
    .clk          (clk),
    .reset        (reset),
    .dx_val       (dx_val),
    .dx           (dx),
    .x_back       (x_back),
    .m_back       (m_back),
    .x_tag        (x_tag),
    .dmemreq_val  (dmemreq_val),
    .dmemreq_rdy  (dmemreq_rdy),
    .dmemreq_type (dmemreq_type),
    .redirect     (redirect),
    .xm_val       (xm_val),
    .xm_ctrl      (xm_ctrl),
    .xm_inst      (xm_inst)
  );

  pctl_result result0 (
    .clk          (clk),
    .reset        (reset),
    .xm_val       (xm_val),
    .xm_ctrl      (xm_ctrl),
    .xm_inst      (xm_inst),
    .m_back       (m_back),
    .m_tag        (m_tag),
    .w_tag        (w_tag),
    .dmemresp_val (dmemresp_val),
    .dmemresp_rdy (dmemresp_rdy),
    .ret_val      (ret_val),
    .ret_rdy      (ret_rdy),
    .ret          (ret)
  );

endmodule

// ==== tests/pctl_assertions.sv ====
// Pipeline control checks
// Handshake stability, redirect source and hazard stalls

`timescale 1ns/1ps
`include "pctl_cfg.svh"

module pctl_assertions (
  input logic                 clk,
  input logic                 reset,
  input logic                 inst_val,
  input logic                 inst_rdy,
  input pctl_pkg::inst_word_t inst,
  input pctl_pkg::br_flags_t  flags,
  input logic                 dmemreq_val,
  input logic                 dmemreq_rdy,
  input pctl_pkg::mem_type_e  dmemreq_type,
  input logic                 ret_val,
  input logic                 ret_rdy,
  input pctl_pkg::retire_t    ret,
  input logic                 redirect,
  input logic                 x_val,
  input pctl_pkg::inst_word_t x_inst,
  input logic                 d_hazard,
  input logic                 d_val,
  input pctl_pkg::inst_word_t d_inst
);

  inst_hold: assert property (@(posedge clk) disable iff (reset)
    inst_val && !inst_rdy |=> inst_val && $stable(inst) && $stable(flags))
    else $error("instruction stream changed while waiting for inst_rdy");

  ret_hold: assert property (@(posedge clk) disable iff (reset)
    ret_val && !ret_rdy |=> ret_val && $stable(ret))
    else $error("retire record changed while waiting for ret_rdy");

  // Type stays put while the request is still offered
  req_type_hold: assert property (@(posedge clk) disable iff (reset)
    (dmemreq_val && !dmemreq_rdy) ##1 dmemreq_val |-> $stable(dmemreq_type))
    else $error("memory request type changed while waiting for dmemreq_rdy");

  // Only a beq or bne word in execute may redirect
  redirect_src: assert property (@(posedge clk) disable iff (reset)
    redirect |-> x_val &&
      (x_inst[31:26] == `PCTL_OP_BEQ || x_inst[31:26] == `PCTL_OP_BNE))
    else $error("redirect without a valid branch in execute");

  // Decode keeps a stalled instruction unless a redirect squashes it
  hazard_hold: assert property (@(posedge clk) disable iff (reset)
    d_hazard && !redirect |=> d_val && $stable(d_inst))
    else $error("instruction left decode during a hazard");

endmodule

bind pctl_top pctl_assertions asrt0 (
  .clk          (clk),
  .reset        (reset),
  .inst_val     (inst_val),
  .inst_rdy     (inst_rdy),
  .inst         (inst),
  .flags        (flags),
  .dmemreq_val  (dmemreq_val),
  .dmemreq_rdy  (dmemreq_rdy),
  .dmemreq_type (dmemreq_type),
  .ret_val      (ret_val),
  .ret_rdy      (ret_rdy),
  .ret          (ret),
  .redirect     (redirect),
  .x_val        (execute0.x_val),
  .x_inst       (xm_inst),
  .d_hazard     (decode0.hazard),
  .d_val        (decode0.d_val),
  .d_inst       (dx.inst)
);

// ==== tests/pctl_tb.sv ====
// Testbench for the pipeline control unit
// Replays the instruction table, models the data memory and checks every retirement

`timescale 1ns/1ps

module pctl_tb;

  localparam int WAIT_LIMIT = 200;   // Cycles before any wait gives up
  localparam int MAX_RECS   = 63;

  logic                 clk;
  logic                 reset;
  logic                 inst_val;
  logic                 inst_rdy;
  pctl_pkg::inst_word_t inst;
  pctl_pkg::br_flags_t  flags;
  logic                 dmemreq_val;
  logic                 dmemreq_rdy;
  pctl_pkg::mem_type_e  dmemreq_type;
  logic                 dmemresp_val;
  logic                 dmemresp_rdy;
  logic                 ret_val;
  logic                 ret_rdy;
  pctl_pkg::retire_t    ret;
  logic                 redirect;

  logic [31:0]          tdata [0:255];
  int                   num_recs;
  int                   cur_idx;          // Record on the instruction stream
  int                   exp_q[$];         // Records due to retire, oldest first
  logic [1:0]           mem_q[$];         // Memory types due at the request port
  int                   outstanding;
  int                   seed;
  int                   accepted;
  int                   retired;
  int                   squashed;
  int                   value_errors;
  int                   other_errors;
  int                   ret_idx;
  pctl_pkg::ctrl_word_t acc_ctrl;
  logic                 window;           // Taken branch seen, redirect not yet over
  logic                 saw_redirect;
  logic                 timed_out;

  pctl_top dut0 (
    .clk          (clk),
    .reset        (reset),
    .inst_val     (inst_val),
    .inst_rdy     (inst_rdy),
    .inst         (inst),
    .flags        (flags),
    .dmemreq_val  (dmemreq_val),
    .dmemreq_rdy  (dmemreq_rdy),
    .dmemreq_type (dmemreq_type),
    .dmemresp_val (dmemresp_val),
    .dmemresp_rdy (dmemresp_rdy),
    .ret_val      (ret_val),
    .ret_rdy      (ret_rdy),
    .ret          (ret),
    .redirect     (redirect)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // ----------------------------------------------------------------------
  // Test data access, four words per record after the count
  // ----------------------------------------------------------------------

  function automatic logic [31:0] record_word(input int idx);
    return tdata[1 + 4*idx];
  endfunction

  function automatic pctl_pkg::br_flags_t record_flags(input int idx);
    return tdata[2 + 4*idx][2:0];
  endfunction

  function automatic pctl_pkg::ctrl_word_t record_ctrl(input int idx);
    return tdata[3 + 4*idx][14:0];
  endfunction

  function automatic logic record_taken(input int idx);
    return tdata[4 + 4*idx][0];
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("Error: time %0t, %s = %0h, expected %0h", $time, name, got, exp);
      value_errors++;
    end
  endtask

  task automatic report_failure(input string what);
    $display("Failure at time %0t: %s", $time, what);
    other_errors++;
  endtask

  // Offers one record and holds it until the DUT takes it
  task automatic send_inst(input int idx);
    int waited;
    cur_idx  = idx;
    inst_val = 1'b1;
    inst     = record_word(idx);
    flags    = record_flags(idx);
    waited   = 0;
    @(negedge clk);
    while (!inst_rdy && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!inst_rdy) begin
      $display("Timeout: record %0d was never accepted by the DUT", idx);
      other_errors++;
      timed_out = 1'b1;
    end
    @(posedge clk);
    #1;
  endtask

  // Random memory timing and retire back-pressure
  always @(posedge clk) begin
    #1;
    dmemreq_rdy  = ($random(seed) & 3) != 0;
    dmemresp_val = (outstanding != 0) && (($random(seed) & 3) != 0);
    ret_rdy      = ($random(seed) & 3) != 0;
  end

  // ----------------------------------------------------------------------
  // Monitor, sampled mid-cycle so every handshake is settled
  // ----------------------------------------------------------------------

  always @(negedge clk) begin
    if (reset) begin
      check_value("outputs in reset",
                  64'({inst_rdy, dmemreq_val, dmemresp_rdy, ret_val, redirect}), 64'd0);
    end else begin
      if (window && saw_redirect && !redirect) begin
        window       = 1'b0;              // Squash shadow ends here
        saw_redirect = 1'b0;
      end
      if (redirect) begin
        if (window) saw_redirect = 1'b1;
        else report_failure("redirect raised with no taken branch outstanding");
      end

      if (inst_val && inst_rdy) begin
        accepted++;
        if (window) begin
          squashed++;                     // Younger than a taken branch
        end else begin
          acc_ctrl = record_ctrl(cur_idx);
          exp_q.push_back(cur_idx);
          if (acc_ctrl.mem_type != pctl_pkg::MEM_NONE) mem_q.push_back(acc_ctrl.mem_type);
          if (record_taken(cur_idx)) window = 1'b1;
        end
      end

      if (dmemresp_val && dmemresp_rdy) begin
        if (outstanding == 0) report_failure("memory response taken with no request open");
        else outstanding--;
      end
      if (dmemreq_val && dmemreq_rdy) begin
        outstanding++;
        if (mem_q.size() == 0) report_failure("data-memory request with no load or store due");
        else check_value("dmemreq_type", 64'(dmemreq_type), 64'(mem_q.pop_front()));
      end

      if (ret_val && ret_rdy) begin
        retired++;
        if (exp_q.size() == 0) begin
          report_failure("instruction retired with none expected");
        end else begin
          ret_idx = exp_q.pop_front();
          check_value("ret.inst", 64'(ret.inst), 64'(record_word(ret_idx)));
          check_value("ret.ctrl", 64'(ret.ctrl), 64'(record_ctrl(ret_idx)));
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------

  initial begin
    int waited;
    seed         = 79534;
    reset        = 1'b1;
    inst_val     = 1'b0;
    inst         = '0;
    flags        = '0;
    dmemreq_rdy  = 1'b0;
    dmemresp_val = 1'b0;
    ret_rdy      = 1'b0;
    cur_idx      = 0;
    outstanding  = 0;
    accepted     = 0;
    retired      = 0;
    squashed     = 0;
    value_errors = 0;
    other_errors = 0;
    window       = 1'b0;
    saw_redirect = 1'b0;
    timed_out    = 1'b0;

    $readmemh("tests/pctl_testdata.txt", tdata);
    num_recs = int'(tdata[0]);

    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;

    if (num_recs < 1 || num_recs > MAX_RECS) begin
      report_failure("test data holds no usable record count");
    end else begin
      for (int i = 0; i < num_recs && !timed_out; i++) begin
        send_inst(i);
      end
    end
    inst_val = 1'b0;

    if (!timed_out) begin
      waited = 0;
      while ((exp_q.size() != 0 || outstanding != 0) && waited < WAIT_LIMIT) begin
        @(posedge clk);
        waited++;
      end
      if (exp_q.size() != 0 || outstanding != 0) begin
        report_failure("pipeline did not drain before the timeout");
      end
      repeat (8) @(posedge clk);          // Room for a stray late retire
      if (window) report_failure("a taken branch never raised redirect");
      check_value("pending memory requests", 64'(mem_q.size()), 64'd0);
      check_value("retired count", 64'(retired), 64'(accepted - squashed));
    end

    $display("Summary: %0d accepted, %0d retired, %0d squashed, %0d value errors, %0d %s",
             accepted, retired, squashed, value_errors, other_errors, "other errors");
    if (value_errors == 0 && other_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== tests/pctl_testdata.txt ====
// Record count first, then per line: inst word, flags {eq,neg,zero},
// expected ctrl {legal,alu_fn,op1_sel,wb_sel,mem_type,wen,waddr}, taken
0000001f
00000000 0 7e00 0  // nop
24010005 0 4221 0  // addiu $1,$0,5
00211021 0 4022 0  // addu $2,$1,$1
00411823 0 4823 0  // subu $3,$2,$1
3c041234 0 6424 0  // lui $4,0x1234
00832824 0 5025 0  // and $5,$4,$3
00a23025 0 5826 0  // or $6,$5,$2
ac260008 0 4280 0  // sw $6,8($1)
8c270008 0 4367 0  // lw $7,8($1)
00e71021 0 4022 0  // addu $2,$7,$7
10220004 4 7800 1  // beq $1,$2 taken
24030001 0 4223 0  // addiu $3,$0,1
8c040000 0 4364 0  // lw $4,0($0)
00212825 0 5825 0  // or $5,$1,$1
14200002 4 7800 0  // bne $1,$0 not taken
2442ffff 0 4222 0  // addiu $2,$2,-1
1440fffe 0 7800 1  // bne $2,$0 taken
00211820 0 3e00 0  // add, not in table
ac020004 0 4280 0  // sw $2,4($0)
08000010 0 3e00 0  // j, not in table
8c410000 0 4361 0  // lw $1,0($2)
8c220004 0 4362 0  // lw $2,4($1)
00420021 0 4020 0  // addu $0,$2,$2
00001821 0 4023 0  // addu $3,$0,$0
10630001 5 7800 1  // beq $3,$3 taken
00632023 0 4824 0  // subu $4,$3,$3
00000001 0 3e00 0  // unknown function code
ac640000 0 4280 0  // sw $4,0($3)
10000003 2 7800 0  // beq $0,$0 not taken
3c07ffff 0 6427 0  // lui $7,0xffff
00000000 0 7e00 0  // nop

// ==== files.f ====
+incdir+design
design/pctl_pkg.sv
design/pctl_stage_ctrl.sv
design/pctl_decode.sv
design/pctl_execute.sv
design/pctl_result.sv
design/pctl_top.sv
tests/pctl_assertions.sv
tests/pctl_tb.sv

// ==== Makefile ====
# Verilator flow for the pipeline control unit

VERILATOR  = verilator
TOP        = pctl_tb
FILELIST   = files.f
OBJ_DIR    = obj_dir
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing --assert
PASS_MSG   = PASS: all tests

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass only when the testbench prints the pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
